// File: bench/core_pipe_vectors.svh
`ifndef CORE_PIPE_VECTORS_SVH
`define CORE_PIPE_VECTORS_SVH

// rows run from pc 0x100 in steps of 4 and carry their expected writeback or branch
task automatic load_table();
    // operands forwarded at distances one, two and three
    add_write(i_type(12'h005, 5'd0, 3'b000, 5'd1, OPC_IMM), 5'd1, 32'h0000_0005);
    add_write(i_type(12'hffd, 5'd0, 3'b000, 5'd2, OPC_IMM), 5'd2, 32'hffff_fffd);
    add_write(r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd3), 5'd3, 32'h0000_0002);
    add_write(r_type(7'h20, 5'd1, 5'd3, 3'b000, 5'd4), 5'd4, 32'hffff_fffd);
    // signed compare and arithmetic shifts of a negative value
    add_write(r_type(7'h00, 5'd1, 5'd4, 3'b010, 5'd5), 5'd5, 32'h0000_0001);
    add_write(i_type(12'hffc, 5'd4, 3'b010, 5'd6, OPC_IMM), 5'd6, 32'h0000_0000);
    add_write(r_type(7'h20, 5'd5, 5'd4, 3'b101, 5'd7), 5'd7, 32'hffff_fffe);
    add_write(i_type(12'h404, 5'd4, 3'b101, 5'd8, OPC_IMM), 5'd8, 32'hffff_ffff);
    // shift amount 33 keeps only its low five bits
    add_write(i_type(12'h021, 5'd0, 3'b000, 5'd9, OPC_IMM), 5'd9, 32'h0000_0021);
    add_write(r_type(7'h00, 5'd9, 5'd1, 3'b001, 5'd10), 5'd10, 32'h0000_000a);
    add_write(r_type(7'h00, 5'd9, 5'd4, 3'b101, 5'd11), 5'd11, 32'h7fff_fffe);
    add_write(i_type(12'h01f, 5'd1, 3'b001, 5'd12, OPC_IMM), 5'd12, 32'h8000_0000);
    // logic ops and their immediate forms
    add_write(r_type(7'h00, 5'd1, 5'd4, 3'b111, 5'd13), 5'd13, 32'h0000_0005);
    add_write(r_type(7'h00, 5'd10, 5'd2, 3'b110, 5'd14), 5'd14, 32'hffff_ffff);
    add_write(r_type(7'h00, 5'd1, 5'd14, 3'b100, 5'd15), 5'd15, 32'hffff_fffa);
    add_write(i_type(12'h0f0, 5'd15, 3'b111, 5'd16, OPC_IMM), 5'd16, 32'h0000_00f0);
    add_write(i_type(12'h00f, 5'd16, 3'b110, 5'd17, OPC_IMM), 5'd17, 32'h0000_00ff);
    add_write(i_type(12'hfff, 5'd17, 3'b100, 5'd18, OPC_IMM), 5'd18, 32'hffff_ff00);
    // x0 is written and then read back as zero
    add_silent(i_type(12'h007, 5'd1, 3'b000, 5'd0, OPC_IMM));
    add_write(r_type(7'h00, 5'd1, 5'd0, 3'b000, 5'd19), 5'd19, 32'h0000_0005);
    // store forwarded data to word 62 and load it back
    add_silent(s_type(12'h008, 5'd19, 5'd16));
    add_write(i_type(12'h008, 5'd16, 3'b010, 5'd20, OPC_LOAD), 5'd20, 32'h0000_0005);
    mark_load_gap();
    add_write(r_type(7'h00, 5'd20, 5'd20, 3'b000, 5'd21), 5'd21, 32'h0000_000a);
    add_silent(s_type(12'h000, 5'd21, 5'd0));
    add_write(i_type(12'h000, 5'd0, 3'b010, 5'd22, OPC_LOAD), 5'd22, 32'h0000_000a);
    mark_load_gap();
    // beq and bne both taken and not taken
    add_branch(b_type(13'h0010, 5'd21, 5'd22, 3'b000), 1'b1, 32'h0000_0174);
    add_branch(b_type(13'h0010, 5'd2, 5'd1, 3'b000), 1'b0, 32'h0000_016c);
    add_branch(b_type(13'h1ff4, 5'd2, 5'd1, 3'b001), 1'b1, 32'h0000_0160);
    add_branch(b_type(13'h0008, 5'd1, 5'd19, 3'b001), 1'b0, 32'h0000_0174);
    // jumps with link where the jalr base is forwarded from the jal
    add_link(j_type(21'h000020, 5'd23), 5'd23, 32'h0000_0178, 32'h0000_0194);
    add_link(i_type(12'h008, 5'd23, 3'b000, 5'd24, OPC_JALR), 5'd24, 32'h0000_017c,
             32'h0000_0180);
    add_branch(j_type(21'h1ffff8, 5'd0), 1'b1, 32'h0000_0174);
    add_write(r_type(7'h00, 5'd23, 5'd24, 3'b000, 5'd25), 5'd25, 32'h0000_02f4);
    // logical right shift of a negative value by an immediate amount
    add_write(i_type(12'h004, 5'd4, 3'b101, 5'd26, OPC_IMM), 5'd26, 32'h0fff_ffff);
endtask

`endif

// File: bench/core_pipe_tb.sv
`timescale 1ns/1ps
`default_nettype none

module core_pipe_tb;

    localparam logic [31:0] BASE_PC    = 32'h0000_0100;
    localparam int          WB_DELAY   = 3;
    localparam int          BR_DELAY   = 1;
    localparam logic [6:0]  OPC_REG    = 7'b0110011;
    localparam logic [6:0]  OPC_IMM    = 7'b0010011;
    localparam logic [6:0]  OPC_LOAD   = 7'b0000011;
    localparam logic [6:0]  OPC_STORE  = 7'b0100011;
    localparam logic [6:0]  OPC_BRANCH = 7'b1100011;
    localparam logic [6:0]  OPC_JAL    = 7'b1101111;
    localparam logic [6:0]  OPC_JALR   = 7'b1100111;

    // one table row, idle_after leaves a load-use gap behind it
    typedef struct packed {
        logic [31:0] instr;
        logic        idle_after;
        logic        wb_en;
        logic [4:0]  wb_rd;
        logic [31:0] wb_data;
        logic        br_en;
        logic        br_taken;
        logic [31:0] br_target;
    } row_t;

    typedef struct packed {
        logic [4:0]  rd;
        logic [31:0] data;
        int          cycle;
    } wb_exp_t;

    typedef struct packed {
        logic [31:0] pc;
        logic        taken;
        logic [31:0] target;
        int          cycle;
    } br_exp_t;

    logic        clk;
    logic        rst_n;
    logic        instr_valid;
    logic [31:0] instr;
    logic [31:0] instr_pc;
    logic        mem_stall;
    logic        wb_valid;
    logic [4:0]  wb_rd;
    logic [31:0] wb_data;
    logic        branch_valid;
    logic [31:0] branch_pc;
    logic        branch_taken;
    logic [31:0] branch_target;

    row_t    rows[$];
    wb_exp_t wb_queue[$];
    br_exp_t br_queue[$];
    integer  seed;
    int      cycle_count = 0;
    int      timeout_limit = 0;
    int      value_errors = 0;
    int      order_errors = 0;
    logic    table_ready = 1'b0;
    logic    stall_pass;

    core_pipe i_dut (
        .clk           (clk),
        .rst_n         (rst_n),
        .instr_valid   (instr_valid),
        .instr         (instr),
        .instr_pc      (instr_pc),
        .mem_stall     (mem_stall),
        .wb_valid      (wb_valid),
        .wb_rd         (wb_rd),
        .wb_data       (wb_data),
        .branch_valid  (branch_valid),
        .branch_pc     (branch_pc),
        .branch_taken  (branch_taken),
        .branch_target (branch_target)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    // instruction encoders, straight from the RV32I formats
    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OPC_REG};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    // word store only
    function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE};
    endfunction

    function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
    endfunction

    task automatic push_row(input logic [31:0] word, input logic wb_en, input logic [4:0] rd,
                            input logic [31:0] data, input logic br_en, input logic taken,
                            input logic [31:0] target);
        row_t r;
        r.instr      = word;
        r.idle_after = 1'b0;
        r.wb_en      = wb_en;
        r.wb_rd      = rd;
        r.wb_data    = data;
        r.br_en      = br_en;
        r.br_taken   = taken;
        r.br_target  = target;
        rows.push_back(r);
    endtask

    task automatic add_write(input logic [31:0] word, input logic [4:0] rd,
                             input logic [31:0] data);
        push_row(word, 1'b1, rd, data, 1'b0, 1'b0, 32'h0);
    endtask

    task automatic add_silent(input logic [31:0] word);
        push_row(word, 1'b0, 5'd0, 32'h0, 1'b0, 1'b0, 32'h0);
    endtask

    task automatic add_branch(input logic [31:0] word, input logic taken,
                              input logic [31:0] target);
        push_row(word, 1'b0, 5'd0, 32'h0, 1'b1, taken, target);
    endtask

    task automatic add_link(input logic [31:0] word, input logic [4:0] rd,
                            input logic [31:0] data, input logic [31:0] target);
        push_row(word, 1'b1, rd, data, 1'b1, 1'b1, target);
    endtask

    task automatic mark_load_gap();
        row_t r;
        r = rows.pop_back();
        r.idle_after = 1'b1;
        rows.push_back(r);
    endtask

    `include "core_pipe_vectors.svh"

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("FAIL at %0t: %s = %h, expected %h", $time, name, got, expected);
            value_errors++;
        end
    endtask

    task automatic check_writeback();
        wb_exp_t e;
        if (wb_valid && wb_queue.size() == 0) begin
            $display("writeback to x%0d at %0t arrived while none was pending", wb_rd, $time);
            order_errors++;
        end else if (wb_valid) begin
            e = wb_queue.pop_front();
            check_value("wb_rd", 32'(wb_rd), 32'(e.rd));
            check_value("wb_data", wb_data, e.data);
            if (!stall_pass) begin
                check_value("wb latency", 32'(cycle_count - e.cycle), 32'(WB_DELAY));
            end
        end
    endtask

    task automatic check_branch();
        br_exp_t e;
        if (branch_valid && br_queue.size() == 0) begin
            $display("branch at pc %h at %0t arrived while none was pending", branch_pc, $time);
            order_errors++;
        end else if (branch_valid) begin
            e = br_queue.pop_front();
            check_value("branch_pc", branch_pc, e.pc);
            check_value("branch_taken", 32'(branch_taken), 32'(e.taken));
            check_value("branch_target", branch_target, e.target);
            if (!stall_pass) begin
                check_value("branch latency", 32'(cycle_count - e.cycle), 32'(BR_DELAY));
            end
        end
    endtask

    // outputs settle well before the falling edge
    always @(negedge clk) begin
        if (rst_n) begin
            check_writeback();
            check_branch();
        end
    end

    task automatic apply_reset();
        rst_n = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;
    endtask

    task automatic run_table(input logic with_stalls);
        int      idx;
        logic    gap;
        row_t    r;
        wb_exp_t w;
        br_exp_t b;
        idx = 0;
        gap = 1'b0;
        while (idx < rows.size()) begin
            @(posedge clk);
            #1;
            instr_valid = 1'b0;
            mem_stall   = with_stalls && (($random(seed) & 3) == 0);
            if (!mem_stall && gap) begin
                gap = 1'b0;
            end else if (!mem_stall) begin
                r           = rows[idx];
                instr_valid = 1'b1;
                instr       = r.instr;
                instr_pc    = BASE_PC + 32'(4 * idx);
                if (r.wb_en) begin
                    w.rd    = r.wb_rd;
                    w.data  = r.wb_data;
                    w.cycle = cycle_count;
                    wb_queue.push_back(w);
                end
                if (r.br_en) begin
                    b.pc     = instr_pc;
                    b.taken  = r.br_taken;
                    b.target = r.br_target;
                    b.cycle  = cycle_count;
                    br_queue.push_back(b);
                end
                gap = r.idle_after;
                idx++;
            end
        end
        @(posedge clk);
        #1;
        instr_valid = 1'b0;
        mem_stall   = 1'b0;
    endtask

    // a few spare cycles catch results that were never expected
    task automatic wait_drained();
        while (wb_queue.size() != 0 || br_queue.size() != 0) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);
        #1;
    endtask

    initial begin
        rst_n       = 1'b0;
        instr_valid = 1'b0;
        instr       = 32'h0;
        instr_pc    = 32'h0;
        mem_stall   = 1'b0;
        seed        = 32'hbb5b;
        stall_pass  = 1'b0;
        load_table();
        // both passes at twice the table each, plus reset and drain
        timeout_limit = 2 * (2 * rows.size()) + 50;
        table_ready   = 1'b1;
        apply_reset();
        run_table(1'b0);
        wait_drained();
        // second pass from a clean state with random stalls
        stall_pass = 1'b1;
        apply_reset();
        run_table(1'b1);
        wait_drained();
        $display("errors: %0d wrong values, %0d unexpected results", value_errors, order_errors);
        if (value_errors == 0 && order_errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    initial begin
        wait (table_ready);
        wait (cycle_count >= timeout_limit);
        $display("timeout: results still missing after %0d cycles", cycle_count);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: core_pipe.f
+incdir+hdl
+incdir+bench
hdl/core_pkg.sv
hdl/stage_links.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/result_stage.sv
hdl/core_pipe.sv
bench/core_pipe_tb.sv

// File: hdl/core_pipe.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_settings.svh"

module core_pipe (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              instr_valid,
    input  logic [31:0]       instr,
    input  logic [`XLEN-1:0]  instr_pc,
    input  logic              mem_stall,
    output logic              wb_valid,
    output logic [4:0]        wb_rd,
    output logic [`XLEN-1:0]  wb_data,
    output logic              branch_valid,
    output logic [`XLEN-1:0]  branch_pc,
    output logic              branch_taken,
    output logic [`XLEN-1:0]  branch_target
);

    dec_ex_if dx_link ();
    ex_res_if xr_link ();
    wb_if     wb_link ();

    decode_stage i_decode (
        .clk         (clk),
        .rst_n       (rst_n),
        .stall       (mem_stall),
        .instr_valid (instr_valid),
        .instr       (instr),
        .instr_pc    (instr_pc),
        .dx          (dx_link.decode),
        .wb          (wb_link.decode)
    );

    execute_stage i_execute (
        .clk           (clk),
        .rst_n         (rst_n),
        .stall         (mem_stall),
        .dx            (dx_link.execute),
        .xr            (xr_link.execute),
        .wb            (wb_link.execute),
        .branch_valid  (branch_valid),
        .branch_pc     (branch_pc),
        .branch_target (branch_target),
        .branch_taken  (branch_taken)
    );

    result_stage i_result (
        .clk   (clk),
        .rst_n (rst_n),
        .stall (mem_stall),
        .xr    (xr_link.result),
        .wb    (wb_link.source)
    );

    assign wb_valid = wb_link.valid;
    assign wb_rd    = wb_link.rd;
    assign wb_data  = wb_link.data;

endmodule

`default_nettype wire

// File: hdl/core_pkg.sv
`default_nettype none

package core_pkg;

    // major opcodes of the supported RV32I subset
    typedef enum logic [6:0] {
        OP_REG    = 7'b0110011,
        OP_IMM    = 7'b0010011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_BRANCH = 7'b1100011,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLL  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_SLT  = 4'd8,
        // link address, pc plus 4
        ALU_LINK = 4'd9
    } alu_op_e;

    typedef enum logic [2:0] {
        BR_NONE = 3'd0,
        BR_JAL  = 3'd1,
        BR_JALR = 3'd2,
        BR_EQ   = 3'd3,
        BR_NE   = 3'd4
    } branch_kind_e;

    typedef enum logic [1:0] {
        MEM_NONE  = 2'd0,
        MEM_LOAD  = 2'd1,
        MEM_STORE = 2'd2
    } mem_op_e;

    // decoded control carried from decode into execute
    typedef struct packed {
        alu_op_e      alu_op;
        logic         use_imm;
        branch_kind_e branch_kind;
        mem_op_e      mem_op;
        logic         reg_write;
    } ex_ctrl_t;

endpackage

`default_nettype wire

// File: hdl/core_settings.svh
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// data path and address width
`define XLEN 32

// architectural integer registers, x0 reads as zero
`define REG_COUNT 32

// data memory depth in 32-bit words
`define DMEM_WORDS 64

`endif

// File: hdl/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_settings.svh"

module decode_stage (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              stall,
    input  logic              instr_valid,
    input  logic [31:0]       instr,
    input  logic [`XLEN-1:0]  instr_pc,
    dec_ex_if.decode          dx,
    wb_if.decode              wb
);
    import core_pkg::*;

    logic [`XLEN-1:0] regs [`REG_COUNT];

    opcode_e          opcode;
    logic [2:0]       funct3;
    logic [6:0]       funct7;
    logic [4:0]       rs1;
    logic [4:0]       rs2;
    logic [`XLEN-1:0] imm_i;
    logic [`XLEN-1:0] imm_s;
    logic [`XLEN-1:0] imm_b;
    logic [`XLEN-1:0] imm_j;
    logic [`XLEN-1:0] imm;
    ex_ctrl_t         ctrl;
    logic             known;

    assign opcode = opcode_e'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];

    // sign-extended immediates for each format
    assign imm_i = {{(`XLEN-12){instr[31]}}, instr[31:20]};
    assign imm_s = {{(`XLEN-12){instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{(`XLEN-13){instr[31]}}, instr[31], instr[7], instr[30:25],
                    instr[11:8], 1'b0};
    assign imm_j = {{(`XLEN-21){instr[31]}}, instr[31], instr[19:12], instr[20],
                    instr[30:21], 1'b0};

    // funct3 to ALU operation, alt selects SUB or SRA
    function automatic alu_op_e arith_op(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  arith_op = alt ? ALU_SUB : ALU_ADD;
            3'b001:  arith_op = ALU_SLL;
            3'b010:  arith_op = ALU_SLT;
            3'b100:  arith_op = ALU_XOR;
            3'b101:  arith_op = alt ? ALU_SRA : ALU_SRL;
            3'b110:  arith_op = ALU_OR;
            default: arith_op = ALU_AND;
        endcase
    endfunction

    // register read, a writeback in the same cycle wins over the array
    function automatic logic [`XLEN-1:0] read_reg(input logic [4:0] idx);
        if (wb.valid && wb.rd == idx) begin
            read_reg = wb.data;
        end else begin
            read_reg = regs[idx];
        end
    endfunction

    always_comb begin
        ctrl  = '{alu_op: ALU_ADD, use_imm: 1'b0, branch_kind: BR_NONE,
                  mem_op: MEM_NONE, reg_write: 1'b0};
        imm   = imm_i;
        known = 1'b1;
        case (opcode)
            OP_REG: begin
                ctrl.alu_op    = arith_op(funct3, funct7[5]);
                ctrl.reg_write = 1'b1;
                // SLTU is not supported, funct7 only marks SUB and SRA
                known = (funct3 != 3'b011) && ((funct7 == 7'h00) ||
                        (funct7 == 7'h20 && (funct3 == 3'b000 || funct3 == 3'b101)));
            end
            OP_IMM: begin
                ctrl.alu_op    = arith_op(funct3, funct3 == 3'b101 && funct7[5]);
                ctrl.use_imm   = 1'b1;
                ctrl.reg_write = 1'b1;
                if (funct3 == 3'b011) begin
                    known = 1'b0;
                end else if (funct3 == 3'b001) begin
                    known = (funct7 == 7'h00);
                end else if (funct3 == 3'b101) begin
                    known = (funct7 == 7'h00) || (funct7 == 7'h20);
                end
            end
            OP_LOAD: begin
                ctrl.use_imm   = 1'b1;
                ctrl.mem_op    = MEM_LOAD;
                ctrl.reg_write = 1'b1;
                known = (funct3 == 3'b010);
            end
            OP_STORE: begin
                ctrl.use_imm = 1'b1;
                ctrl.mem_op  = MEM_STORE;
                imm   = imm_s;
                known = (funct3 == 3'b010);
            end
            OP_BRANCH: begin
                // compare by subtracting the two registers
                ctrl.alu_op      = ALU_SUB;
                ctrl.branch_kind = (funct3 == 3'b001) ? BR_NE : BR_EQ;
                imm   = imm_b;
                known = (funct3 == 3'b000) || (funct3 == 3'b001);
            end
            OP_JAL: begin
                ctrl.alu_op      = ALU_LINK;
                ctrl.branch_kind = BR_JAL;
                ctrl.reg_write   = 1'b1;
                imm = imm_j;
            end
            OP_JALR: begin
                ctrl.alu_op      = ALU_LINK;
                ctrl.branch_kind = BR_JALR;
                ctrl.reg_write   = 1'b1;
                known = (funct3 == 3'b000);
            end
            default: begin
                known = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.valid && !stall) begin
            regs[wb.rd] <= wb.data;
        end
    end

    // bubble when no strobe or the encoding is unknown
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dx.valid <= 1'b0;
            dx.ctrl  <= '0;
        end else if (!stall) begin
            dx.valid <= instr_valid && known;
            dx.ctrl  <= ctrl;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            dx.pc       <= instr_pc;
            dx.rs1_data <= read_reg(rs1);
            dx.rs2_data <= read_reg(rs2);
            dx.imm      <= imm;
            dx.rs1      <= rs1;
            dx.rs2      <= rs2;
            dx.rd       <= instr[11:7];
        end
    end

endmodule

`default_nettype wire

// File: hdl/execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_settings.svh"

module execute_stage (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              stall,
    dec_ex_if.execute         dx,
    ex_res_if.execute         xr,
    wb_if.execute             wb,
    output logic              branch_valid,
    output logic [`XLEN-1:0]  branch_pc,
    output logic [`XLEN-1:0]  branch_target,
    output logic              branch_taken
);
    import core_pkg::*;

    logic             ex_writes;
    logic [`XLEN-1:0] op_a;
    logic [`XLEN-1:0] rs2_fwd;
    logic [`XLEN-1:0] op_b;
    logic [4:0]       shamt;
    logic [`XLEN-1:0] alu_result;
    logic [`XLEN-1:0] pc_imm;
    logic [`XLEN-1:0] pc_next;
    logic             sub_zero;

    // the instruction one ahead is still in the execute register
    assign ex_writes = xr.valid && xr.reg_write && (xr.rd != 5'd0);

    // newest value first, then the writeback bus, then the register file
    function automatic logic [`XLEN-1:0] forward(input logic [4:0] rs,
                                                  input logic [`XLEN-1:0] rf_data);
        if (ex_writes && xr.rd == rs) begin
            forward = xr.alu_result;
        end else if (wb.valid && wb.rd == rs) begin
            forward = wb.data;
        end else begin
            forward = rf_data;
        end
    endfunction

    always_comb begin
        op_a    = forward(dx.rs1, dx.rs1_data);
        rs2_fwd = forward(dx.rs2, dx.rs2_data);
    end

    assign op_b    = dx.ctrl.use_imm ? dx.imm : rs2_fwd;

    // only the low five bits count as shift amount
    assign shamt = op_b[4:0];

    always_comb begin
        case (dx.ctrl.alu_op)
            ALU_ADD:  alu_result = op_a + op_b;
            ALU_SUB:  alu_result = op_a - op_b;
            ALU_AND:  alu_result = op_a & op_b;
            ALU_OR:   alu_result = op_a | op_b;
            ALU_XOR:  alu_result = op_a ^ op_b;
            ALU_SLL:  alu_result = op_a << shamt;
            ALU_SRL:  alu_result = op_a >> shamt;
            ALU_SRA:  alu_result = $signed(op_a) >>> shamt;
            ALU_SLT:  alu_result = {{(`XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            ALU_LINK: alu_result = pc_next;
            default:  alu_result = '0;
        endcase
    end

    assign pc_imm   = dx.pc + dx.imm;
    assign pc_next  = dx.pc + `XLEN'd4;
    assign sub_zero = (alu_result == '0);

    // branch outcome
    always_comb begin
        case (dx.ctrl.branch_kind)
            BR_JAL: begin
                branch_taken  = 1'b1;
                branch_target = pc_imm;
            end
            BR_JALR: begin
                branch_taken  = 1'b1;
                branch_target = op_a + dx.imm;
            end
            BR_EQ: begin
                branch_taken  = sub_zero;
                branch_target = sub_zero ? pc_imm : pc_next;
            end
            BR_NE: begin
                branch_taken  = !sub_zero;
                branch_target = sub_zero ? pc_next : pc_imm;
            end
            default: begin
                branch_taken  = 1'b0;
                branch_target = pc_next;
            end
        endcase
    end

    // held low while frozen so each outcome is reported once
    assign branch_valid = dx.valid && !stall && (dx.ctrl.branch_kind != BR_NONE);
    assign branch_pc    = dx.pc;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            xr.valid     <= 1'b0;
            xr.mem_op    <= MEM_NONE;
            xr.reg_write <= 1'b0;
        end else if (!stall) begin
            xr.valid     <= dx.valid;
            xr.mem_op    <= dx.valid ? dx.ctrl.mem_op : MEM_NONE;
            xr.reg_write <= dx.valid && dx.ctrl.reg_write;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            xr.rd         <= dx.rd;
            xr.alu_result <= alu_result;
            // store data is the forwarded register and not the immediate
            xr.store_data <= rs2_fwd;
        end
    end

endmodule

`default_nettype wire

// File: hdl/result_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_settings.svh"

module result_stage (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      stall,
    ex_res_if.result  xr,
    wb_if.source      wb
);
    import core_pkg::*;

    localparam int unsigned ADDR_W = $clog2(`DMEM_WORDS);

    logic [`XLEN-1:0] dmem [`DMEM_WORDS];
    logic [ADDR_W-1:0] word_idx;
    logic [`XLEN-1:0] load_word;
    logic             wb_valid_q;

    // word address, wraps modulo the memory depth
    assign word_idx  = xr.alu_result[ADDR_W+1:2];
    assign load_word = dmem[word_idx];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `DMEM_WORDS; i++) begin
                dmem[i] <= '0;
            end
        end else if (!stall && xr.valid && xr.mem_op == MEM_STORE) begin
            dmem[word_idx] <= xr.store_data;
        end
    end

    // writes to x0 never reach the bus
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_valid_q <= 1'b0;
        end else if (!stall) begin
            wb_valid_q <= xr.valid && xr.reg_write && (xr.rd != 5'd0);
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            wb.rd   <= xr.rd;
            wb.data <= (xr.mem_op == MEM_LOAD) ? load_word : xr.alu_result;
        end
    end

    // a frozen writeback is presented once, after the stall ends
    assign wb.valid = wb_valid_q && !stall;

endmodule

`default_nettype wire

// File: hdl/stage_links.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_settings.svh"

// decode/execute pipeline register contents
interface dec_ex_if;
    import core_pkg::*;

    logic              valid;
    ex_ctrl_t          ctrl;
    logic [`XLEN-1:0]  pc;
    logic [`XLEN-1:0]  rs1_data;
    logic [`XLEN-1:0]  rs2_data;
    logic [`XLEN-1:0]  imm;
    logic [4:0]        rs1;
    logic [4:0]        rs2;
    logic [4:0]        rd;

    modport decode (output valid, ctrl, pc, rs1_data, rs2_data, imm, rs1, rs2, rd);
    modport execute (input valid, ctrl, pc, rs1_data, rs2_data, imm, rs1, rs2, rd);
endinterface

// execute/memory pipeline register contents
interface ex_res_if;
    import core_pkg::*;

    logic              valid;
    mem_op_e           mem_op;
    logic              reg_write;
    logic [4:0]        rd;
    // memory address for loads and stores, register value otherwise
    logic [`XLEN-1:0]  alu_result;
    logic [`XLEN-1:0]  store_data;

    modport execute (output valid, mem_op, reg_write, rd, alu_result, store_data);
    modport result (input valid, mem_op, reg_write, rd, alu_result, store_data);
endinterface

// writeback bus, valid only for a real register write to rd != 0
interface wb_if;
    logic              valid;
    logic [4:0]        rd;
    logic [`XLEN-1:0]  data;

    modport source (output valid, rd, data);
    modport decode (input valid, rd, data);
    modport execute (input valid, rd, data);
endinterface

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module core_pipe_tb -f core_pipe.f -Mdir obj_dir \
    && ./obj_dir/Vcore_pipe_tb | tee /dev/stderr | grep -q "Simulation finished: PASS" \
    && echo "run_sim: simulation passed" \
    || { echo "run_sim: build or simulation failed"; exit 1; }
